// File: llc_evict_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, descriptor / way / fill / W beat structs and
// the state encoding of the llc write-back unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package llc_evict_pkg;

  localparam int unsigned WAY_W  = 2;   // 4 ways
  localparam int unsigned IDX_W  = 4;   // 16 lines per way
  localparam int unsigned OFF_W  = 2;   // block offset inside a line
  localparam int unsigned BYTE_W = 2;   // byte offset inside a block
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;  // one word == one W beat
  localparam int unsigned STRB_W = DATA_W / 8;

  localparam int unsigned NUM_BLOCKS = 1 << OFF_W;
  localparam int unsigned NUM_LINES  = 1 << IDX_W;
  localparam int unsigned NUM_WAYS   = 1 << WAY_W;
  // line index sits right above byte and block offset
  localparam int unsigned IDX_LSB    = BYTE_W + OFF_W;

  // descriptor handed between cache units, 20 bits
  typedef struct packed {
    logic [WAY_W-1:0]  way_ind;
    logic [ADDR_W-1:0] addr;
    logic              evict;   // line must be written back
    logic              flush;   // descriptor dies in this unit
  } llc_desc_t;

  // read request towards the data way
  typedef struct packed {
    logic [WAY_W-1:0] way_ind;
    logic [IDX_W-1:0] line_idx;
    logic [OFF_W-1:0] blk_off;
  } llc_way_req_t;

  // preload write, no response
  typedef struct packed {
    logic [WAY_W-1:0]  way_ind;
    logic [IDX_W-1:0]  line_idx;
    logic [OFF_W-1:0]  blk_off;
    logic [DATA_W-1:0] data;
  } llc_fill_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;  // always full lines
    logic              last;
  } llc_w_beat_t;

  // encoded as {busy, send}
  typedef enum logic [1:0] {
    IDLE  = 2'b00,  // waiting for a descriptor
    SEND  = 2'b01,  // pass descriptor on or drop a flush
    EVICT = 2'b10,  // read blocks, drain beats
    RESP  = 2'b11   // last beat gone, B still missing
  } evict_state_e;

endpackage

`default_nettype wire

// File: llc_beat_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// loadable up/down counter with sticky wrap flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_beat_counter #(
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             load_i,      // load wins over count
  input  logic [WIDTH-1:0] load_val_i,
  input  logic             en_i,
  input  logic             down_i,      // 1: count towards zero
  output logic [WIDTH-1:0] q_o,
  output logic             wrap_o       // set when the count rolls over
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      q_o    <= '0;
      wrap_o <= 1'b0;
    end else if (load_i) begin
      q_o    <= load_val_i;
      wrap_o <= 1'b0;          // fresh run
    end else if (en_i) begin
      q_o <= down_i ? q_o - 1'b1 : q_o + 1'b1;
      // stays set until the next load
      if (down_i ? (q_o == '0) : (&q_o)) wrap_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: llc_beat_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through circular FIFO for W beat data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_beat_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,  // also low while a word falls through
  output logic             full_o
);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];  // payload, no reset
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             stored_empty;   // nothing held in the array
  logic             wr_adv, rd_adv;

  assign stored_empty = (cnt_q == '0);
  assign empty_o      = stored_empty & ~push_i;
  assign full_o       = (cnt_q == CNT_W'(DEPTH));
  // head of queue, or the incoming word when the array is empty
  assign data_o       = stored_empty ? data_i : mem_q[rd_ptr_q];

  // push and pop on an empty array pass through, array untouched
  assign wr_adv = push_i & ~full_o & ~(stored_empty & pop_i);
  assign rd_adv = pop_i & ~stored_empty;

  always_ff @(posedge clk_i) begin
    if (wr_adv) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_adv) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_adv) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(wr_adv) - CNT_W'(rd_adv);  // net fill change
    end
  end

endmodule

`default_nettype wire

// File: llc_data_way.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data way storage with fill port and registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_data_way (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // preload port
  input  llc_evict_pkg::llc_fill_t            fill_i,
  input  logic                                fill_strobe_i,
  // read request
  input  llc_evict_pkg::llc_way_req_t         req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // read response, one cycle after accept
  output logic [llc_evict_pkg::DATA_W-1:0]    rd_data_o,
  output logic                                rd_valid_o
);
  import llc_evict_pkg::*;

  // ways x lines x blocks, contents survive reset
  logic [DATA_W-1:0] mem_q [NUM_WAYS][NUM_LINES][NUM_BLOCKS];

  logic              rd_accept;  // read handshake this cycle
  logic [DATA_W-1:0] rd_data_q;
  logic              rd_valid_q;

  // fill wins the port, read waits a cycle
  assign req_ready_o = ~fill_strobe_i;
  assign rd_accept   = req_valid_i & req_ready_o;

  // fill write at the edge
  always_ff @(posedge clk_i) begin
    if (fill_strobe_i) begin
      mem_q[fill_i.way_ind][fill_i.line_idx][fill_i.blk_off] <= fill_i.data;
    end
  end

  // read data register, only updated on accept
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rd_data_q <= mem_q[req_i.way_ind][req_i.line_idx][req_i.blk_off];
    end
  end

  // response strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_accept;  // one cycle per accepted read
    end
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

// File: llc_evict_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back control: descriptor register, request sequencing,
// last flag, B wait and descriptor forwarding / flush drop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_evict_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // descriptor in
  input  llc_evict_pkg::llc_desc_t              desc_i,
  input  logic                                  desc_valid_i,
  output logic                                  desc_ready_o,
  // descriptor out
  output llc_evict_pkg::llc_desc_t              desc_o,
  output logic                                  desc_valid_o,
  input  logic                                  desc_ready_i,
  // data way requests
  output llc_evict_pkg::llc_way_req_t           way_req_o,
  output logic                                  way_req_valid_o,
  input  logic                                  way_req_ready_i,
  // counter interface
  input  logic                                  req_done_i,    // offset counter wrapped
  input  logic [llc_evict_pkg::OFF_W-1:0]       offset_i,
  input  logic [llc_evict_pkg::OFF_W-1:0]       beats_left_i,
  output logic                                  cnt_load_o,
  output logic                                  offset_en_o,
  output logic                                  beats_en_o,
  // W / B side
  input  logic                                  pop_i,         // beat left on W
  output logic                                  last_o,
  input  logic                                  b_valid_i,
  output logic                                  b_ready_o,
  output logic                                  flush_done_o
);
  import llc_evict_pkg::*;

  evict_state_e state_q, state_d;
  llc_desc_t    desc_q;     // descriptor in flight
  logic         desc_load;  // input handshake

  assign desc_o       = desc_q;
  assign last_o       = (beats_left_i == '0);
  assign offset_en_o  = way_req_valid_o & way_req_ready_i;
  assign beats_en_o   = pop_i & (state_q == EVICT);

  // line index does not change during the eviction
  assign way_req_o.way_ind  = desc_q.way_ind;
  assign way_req_o.line_idx = desc_q.addr[IDX_LSB +: IDX_W];
  assign way_req_o.blk_off  = offset_i;

  always_comb begin
    state_d         = state_q;
    desc_load       = 1'b0;
    cnt_load_o      = 1'b0;
    desc_ready_o    = 1'b0;
    desc_valid_o    = 1'b0;
    way_req_valid_o = 1'b0;
    b_ready_o       = 1'b0;
    flush_done_o    = 1'b0;

    unique case (state_q)
      IDLE: desc_ready_o = 1'b1;
      SEND: begin
        if (desc_q.flush) begin
          flush_done_o = 1'b1;       // flush ends here, never forwarded
          desc_ready_o = 1'b1;
          state_d      = IDLE;
        end else begin
          desc_valid_o = 1'b1;
          if (desc_ready_i) begin
            desc_ready_o = 1'b1;     // next one may load right away
            state_d      = IDLE;
          end
        end
      end
      EVICT: begin
        way_req_valid_o = ~req_done_i;  // until all blocks requested
        if (pop_i && last_o) begin
          b_ready_o = 1'b1;
          state_d   = b_valid_i ? SEND : RESP;
        end
      end
      RESP: begin
        b_ready_o = 1'b1;
        if (b_valid_i) state_d = SEND;
      end
      default: state_d = IDLE;
    endcase

    // shared load path for IDLE and the end of SEND
    if (desc_ready_o && desc_valid_i) begin
      desc_load  = 1'b1;
      cnt_load_o = desc_i.evict;
      state_d    = desc_i.evict ? EVICT : SEND;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= IDLE;
    else       state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (desc_load) desc_q <= desc_i;
  end

endmodule

`default_nettype wire

// File: llc_evict_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llc write-back unit top: fsm, counters, beat FIFO, data way
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_evict_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  llc_evict_pkg::llc_desc_t       desc_i,
  input  logic                           desc_valid_i,
  output logic                           desc_ready_o,
  output llc_evict_pkg::llc_desc_t       desc_o,
  output logic                           desc_valid_o,
  input  logic                           desc_ready_i,
  output llc_evict_pkg::llc_w_beat_t     w_beat_o,
  output logic                           w_valid_o,
  input  logic                           w_ready_i,
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  input  llc_evict_pkg::llc_fill_t       fill_i,
  input  logic                           fill_strobe_i,
  output logic                           flush_done_o
);
  import llc_evict_pkg::*;

  llc_way_req_t      way_req;
  logic              way_req_valid, way_req_ready;
  logic [DATA_W-1:0] rd_data, fifo_data;
  logic              rd_valid;
  logic              cnt_load, offset_en, beats_en, req_done, last;
  logic [OFF_W-1:0]  offset, beats_left;
  logic              fifo_empty, fifo_pop;

  assign w_valid_o = ~fifo_empty;
  assign fifo_pop  = w_valid_o & w_ready_i;  // beat accepted on W

  assign w_beat_o.data = fifo_data;
  assign w_beat_o.strb = '1;                 // whole words only
  assign w_beat_o.last = last;

  llc_evict_fsm u_fsm (
    .clk_i, .rst_i, .desc_i, .desc_valid_i, .desc_ready_o,
    .desc_o, .desc_valid_o, .desc_ready_i,
    .way_req_o(way_req), .way_req_valid_o(way_req_valid), .way_req_ready_i(way_req_ready),
    .req_done_i(req_done), .offset_i(offset), .beats_left_i(beats_left),
    .cnt_load_o(cnt_load), .offset_en_o(offset_en), .beats_en_o(beats_en),
    .pop_i(fifo_pop), .last_o(last), .b_valid_i, .b_ready_o, .flush_done_o
  );

  // block offset, up from 0, wrap ends the requests
  llc_beat_counter #(.WIDTH(OFF_W)) u_offset_cnt (
    .clk_i, .rst_i, .load_i(cnt_load), .load_val_i('0), .en_i(offset_en),
    .down_i(1'b0), .q_o(offset), .wrap_o(req_done)
  );

  // beats left, zero marks the last beat
  llc_beat_counter #(.WIDTH(OFF_W)) u_beats_cnt (
    .clk_i, .rst_i, .load_i(cnt_load), .load_val_i(OFF_W'(NUM_BLOCKS - 1)),
    .en_i(beats_en), .down_i(1'b1), .q_o(beats_left), .wrap_o()
  );

  // holds a full line so read data never stalls
  llc_beat_fifo #(.WIDTH(DATA_W), .DEPTH(NUM_BLOCKS)) u_beat_fifo (
    .clk_i, .rst_i, .push_i(rd_valid), .data_i(rd_data), .pop_i(fifo_pop),
    .data_o(fifo_data), .empty_o(fifo_empty), .full_o()
  );

  llc_data_way u_data_way (
    .clk_i, .rst_i, .fill_i, .fill_strobe_i,
    .req_i(way_req), .req_valid_i(way_req_valid), .req_ready_o(way_req_ready),
    .rd_data_o(rd_data), .rd_valid_o(rd_valid)
  );

endmodule

`default_nettype wire

// File: llc_evict_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions on write-back state, beat FIFO and descriptor out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module llc_evict_checker (
  input logic                         clk_i,
  input logic                         rst_i,
  input llc_evict_pkg::evict_state_e  state_i,
  input logic                         fifo_empty_i,
  input logic                         w_valid_i,
  input logic                         desc_load_i,     // descriptor taken this cycle
  input logic                         flush_done_i,
  input llc_evict_pkg::llc_desc_t     desc_out_i,
  input logic                         desc_out_valid_i,
  input logic                         desc_out_ready_i
);
  import llc_evict_pkg::*;

  // beats only live while a line is written back
  a_fifo_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == IDLE || state_i == SEND) |-> fifo_empty_i)
    else $error("beat FIFO holds data outside EVICT and RESP");

  a_w_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == IDLE) |-> !w_valid_i)
    else $error("W valid while the FSM is idle");

  // two flush descriptors in a row give back-to-back pulses
  a_flush_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    (flush_done_i && !desc_load_i) |=> !flush_done_i)
    else $error("flush done held longer than one cycle");

  a_desc_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (desc_out_valid_i && !desc_out_ready_i) |=> (desc_out_valid_i && $stable(desc_out_i)))
    else $error("descriptor out changed while stalled");

endmodule

bind llc_evict_top llc_evict_checker chk0 (
  .clk_i, .rst_i,
  .state_i(u_fsm.state_q),
  .fifo_empty_i(fifo_empty),
  .w_valid_i(w_valid_o),
  .desc_load_i(desc_valid_i & desc_ready_o),
  .flush_done_i(flush_done_o),
  .desc_out_i(desc_o),
  .desc_out_valid_i(desc_valid_o),
  .desc_out_ready_i(desc_ready_i)
);

`default_nettype wire

// File: tb_llc_evict.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the llc write-back unit: LFSR stimulus, memory
// and descriptor model, beat / B / descriptor checks, timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_llc_evict;
  import llc_evict_pkg::*;

  localparam int unsigned NUM_DESC    = 60;
  localparam int unsigned FILL_CYCLES = NUM_WAYS * NUM_LINES * NUM_BLOCKS;
  localparam int unsigned MAX_CYCLES  = NUM_DESC * 40 + FILL_CYCLES + 10;  // 10 for reset

  logic        clk, rst;
  llc_desc_t   desc_in, desc_out;
  logic        desc_in_valid, desc_in_ready, desc_out_valid, desc_out_ready;
  llc_w_beat_t w_beat;
  logic        w_valid, w_ready, b_valid, b_ready;
  llc_fill_t   fill;
  logic        fill_strobe, flush_done;

  logic [DATA_W-1:0] model_mem [NUM_WAYS][NUM_LINES][NUM_BLOCKS];  // mirrors every fill
  llc_w_beat_t       exp_beats[$];
  llc_desc_t         exp_descs[$];   // all accepted descriptors, in order
  logic [WAY_W-1:0]  evict_way;      // line still being read out
  logic [IDX_W-1:0]  evict_line;
  int unsigned       b_owed, done_cnt, sent_cnt, cycle_cnt;
  logic [31:0]       lfsr_q;
  logic              desc_hs, b_hs;  // handshakes of the current cycle

  initial clk = 1'b0;
  always #50 clk = ~clk;

  llc_evict_top dut0 (
    .clk_i(clk), .rst_i(rst),
    .desc_i(desc_in), .desc_valid_i(desc_in_valid), .desc_ready_o(desc_in_ready),
    .desc_o(desc_out), .desc_valid_o(desc_out_valid), .desc_ready_i(desc_out_ready),
    .w_beat_o(w_beat), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_ready_o(b_ready),
    .fill_i(fill), .fill_strobe_i(fill_strobe), .flush_done_o(flush_done)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) v = {v[30:0], rand_bit()};  // one step per bit
    return v;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs for the next cycle, applied just after the edge
  task automatic drive_inputs();
    llc_fill_t f;
    if (!desc_in_valid || desc_hs) begin  // hold a descriptor until taken
      desc_in_valid = 1'b0;
      if (sent_cnt < NUM_DESC && rand_bit()) begin
        desc_in.way_ind = WAY_W'(rand_bits(WAY_W));
        desc_in.addr    = ADDR_W'(rand_bits(ADDR_W));
        desc_in.evict   = rand_bit();
        desc_in.flush   = (rand_bits(2) == 32'd3);  // about one in four
        desc_in_valid   = 1'b1;
        sent_cnt++;
      end
    end
    w_ready        = (rand_bits(2) != 32'd0);  // stall about one cycle in four
    desc_out_ready = (rand_bits(2) != 32'd0);
    if (b_hs) b_valid = 1'b0;
    if (!b_valid && b_owed > 0 && rand_bit()) b_valid = 1'b1;  // random B delay
    fill_strobe = (rand_bits(2) == 32'd0);
    if (fill_strobe) begin
      f.way_ind  = WAY_W'(rand_bits(WAY_W));
      f.line_idx = IDX_W'(rand_bits(IDX_W));
      f.blk_off  = OFF_W'(rand_bits(OFF_W));
      f.data     = rand_bits(DATA_W);
      // stay off the line whose beats are still expected
      if (exp_beats.size() > 0 && f.way_ind == evict_way && f.line_idx == evict_line)
        f.line_idx = f.line_idx ^ IDX_W'(1);
      fill = f;
      model_mem[f.way_ind][f.line_idx][f.blk_off] = f.data;  // lands at the next edge
    end
  endtask

  // outputs are settled at the falling edge
  task automatic monitor_outputs();
    llc_w_beat_t eb;
    llc_desc_t   ed;
    desc_hs = desc_in_valid & desc_in_ready;
    b_hs    = b_valid & b_ready;
    if (w_valid && w_ready) begin
      check_eq(64'(exp_beats.size() != 0), 64'd1, "W beat expected by model");
      eb = exp_beats.pop_front();
      check_eq(64'(w_beat), 64'(eb), "W beat");
    end
    if (b_ready) check_eq(64'(b_owed), 64'd1, "B responses owed while B ready");
    if (b_hs) begin
      check_eq(64'(exp_beats.size()), 64'd0, "beats still pending at B");  // B not before last
      b_owed--;
    end
    if (desc_out_valid && desc_out_ready) begin
      check_eq(64'(exp_descs.size() != 0), 64'd1, "descriptor expected by model");
      ed = exp_descs.pop_front();
      check_eq(64'(desc_out), 64'(ed), "forwarded descriptor");
      check_eq(64'(ed.flush), 64'd0, "flush bit of forwarded descriptor");
      check_eq(64'(b_owed), 64'd0, "B owed at descriptor out");
      done_cnt++;
    end
    if (flush_done) begin
      check_eq(64'(exp_descs.size() != 0), 64'd1, "descriptor expected at flush done");
      ed = exp_descs.pop_front();
      check_eq(64'(ed.flush), 64'd1, "flush bit at flush done");
      check_eq(64'(b_owed), 64'd0, "B owed at flush done");
      done_cnt++;
    end
    // load last: the same cycle may end the previous descriptor
    if (desc_hs) begin
      exp_descs.push_back(desc_in);
      if (desc_in.evict) begin
        evict_way  = desc_in.way_ind;
        evict_line = desc_in.addr[BYTE_W + OFF_W +: IDX_W];  // line index above offsets
        for (int unsigned i = 0; i < NUM_BLOCKS; i++) begin
          eb.data = model_mem[evict_way][evict_line][OFF_W'(i)];
          eb.strb = '1;
          eb.last = (i == NUM_BLOCKS - 1);
          exp_beats.push_back(eb);
        end
        b_owed++;
      end
    end
  endtask

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Testbench failed");
    $fatal(1, "timeout after %0d cycles with descriptors still in flight", MAX_CYCLES);
  end

  initial begin
    lfsr_q         = 32'h9bb7ef66;
    rst            = 1'b1;
    desc_in        = '0;
    desc_in_valid  = 1'b0;
    desc_out_ready = 1'b0;
    w_ready        = 1'b0;
    b_valid        = 1'b0;
    fill           = '0;
    fill_strobe    = 1'b0;
    b_owed         = 0;
    done_cnt       = 0;
    sent_cnt       = 0;
    desc_hs        = 1'b0;
    b_hs           = 1'b0;
    evict_way      = '0;
    evict_line     = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_eq(64'(desc_out_valid), 64'd0, "desc valid out after reset");
    check_eq(64'(w_valid), 64'd0, "W valid after reset");
    check_eq(64'(b_ready), 64'd0, "B ready after reset");
    check_eq(64'(flush_done), 64'd0, "flush done after reset");
    check_eq(64'(dut0.way_req_valid), 64'd0, "way request valid after reset");
    check_eq(64'(desc_in_ready), 64'd1, "desc ready after reset");
    check_eq(64'(dut0.u_fsm.state_q), 64'(IDLE), "state after reset");
    // preload every word of every way
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      for (int unsigned l = 0; l < NUM_LINES; l++) begin
        for (int unsigned b = 0; b < NUM_BLOCKS; b++) begin
          @(posedge clk);
          #1;
          fill_strobe = 1'b1;
          fill        = {WAY_W'(w), IDX_W'(l), OFF_W'(b), rand_bits(DATA_W)};
          model_mem[w][l][b] = fill.data;
        end
      end
    end
    while (done_cnt < NUM_DESC) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      monitor_outputs();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: llc_evict.f
llc_evict_pkg.sv
llc_beat_counter.sv
llc_beat_fifo.sv
llc_data_way.sv
llc_evict_fsm.sv
llc_evict_top.sv
llc_evict_checker.sv
tb_llc_evict.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_llc_evict
FILELIST  := llc_evict.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
